// File: src/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand width and register file geometry
`define ALU_DATA_W      8
`define ALU_NUM_REGS    4
`define ALU_REG_SEL_W   2

// AXI4-Lite bus widths
`define AXIL_ADDR_W     8
`define AXIL_DATA_W     32

// register map, operand register n lives at ALU_REG_BASE + 4n
`define ALU_REG_BASE    'h00

// write only, a write here runs one ALU command
`define ALU_CMD_ADDR    'h10

// read only, carry in bit 0 and zero in bit 1
`define ALU_FLAGS_ADDR  'h14

`endif

// File: src/alu_ops_pkg.sv
`include "alu_config.svh"

package alu_ops_pkg;

    // operation codes follow the discrete ALU encoding, gaps are invalid
    typedef enum logic [4:0] {
        OP_A      = 5'd0,
        OP_B      = 5'd1,
        OP_ZERO   = 5'd2,
        OP_NEG_A  = 5'd3,
        OP_NEG_B  = 5'd4,
        OP_INC_A  = 5'd5,
        OP_INC_B  = 5'd6,
        OP_DEC_A  = 5'd7,
        OP_DEC_B  = 5'd8,
        OP_ADD    = 5'd9,
        OP_SUB    = 5'd10,
        OP_MUL_HI = 5'd16,
        OP_MUL_LO = 5'd17,
        OP_AND    = 5'd25,
        OP_OR     = 5'd26
    } alu_op_e;

    // carry sits in bit 0 so the flags register reads back in map order
    typedef struct packed {
        logic zero;
        logic carry;
    } alu_flags_t;

    // command word as written to the command register
    typedef struct packed {
        logic [1:0]                rsvd_hi;
        logic [`ALU_REG_SEL_W-1:0] sel_dst;
        logic [`ALU_REG_SEL_W-1:0] sel_y;
        logic [`ALU_REG_SEL_W-1:0] sel_x;
        logic                      rsvd_lo;
        logic                      force_x_zero;
        logic                      force_pass_x;
        alu_op_e                   op;
    } alu_cmd_t;

    typedef struct packed {
        logic [`ALU_DATA_W-1:0] x;
        logic [`ALU_DATA_W-1:0] y;
        alu_op_e                op;
        logic                   force_pass_x;
        logic                   force_x_zero;
        logic                   cin;
    } alu_req_t;

    typedef struct packed {
        logic [`ALU_DATA_W-1:0] result;
        alu_flags_t             flags;
        logic                   op_valid;
    } alu_res_t;

endpackage

// File: src/axil_pkg.sv
`include "alu_config.svh"

package axil_pkg;

    // only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    // write address channel
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
    } axil_aw_t;

    // write data channel, the strobe is carried but the slave writes whole words
    typedef struct packed {
        logic [`AXIL_DATA_W-1:0]   data;
        logic [`AXIL_DATA_W/8-1:0] strb;
    } axil_w_t;

    // write response channel
    typedef struct packed {
        axil_resp_e resp;
    } axil_b_t;

    // read address channel
    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0] addr;
    } axil_ar_t;

    // read data channel
    typedef struct packed {
        logic [`AXIL_DATA_W-1:0] data;
        axil_resp_e              resp;
    } axil_r_t;

endpackage

// File: src/alu.sv
`include "alu_config.svh"

module alu (
    input  alu_ops_pkg::alu_req_t req,
    output alu_ops_pkg::alu_res_t res
);

    localparam logic [`ALU_DATA_W:0] ONE = {{`ALU_DATA_W{1'b0}}, 1'b1};

    alu_ops_pkg::alu_op_e      op_eff;
    logic [`ALU_DATA_W-1:0]    a;
    logic [`ALU_DATA_W-1:0]    b;
    logic [`ALU_DATA_W:0]      ext_a;
    logic [`ALU_DATA_W:0]      ext_b;
    logic [`ALU_DATA_W:0]      ext_cin;
    logic [2*`ALU_DATA_W-1:0]  product;
    logic [`ALU_DATA_W:0]      wide;
    logic                      valid;

    // the pass override wins over the op code, the zero force only touches operand A
    always_comb begin
        op_eff = req.force_pass_x ? alu_ops_pkg::OP_A : req.op;
        a      = req.force_x_zero ? '0 : req.x;
    end

    assign b       = req.y;
    assign ext_a   = {1'b0, a};
    assign ext_b   = {1'b0, b};
    assign ext_cin = {{`ALU_DATA_W{1'b0}}, req.cin};
    assign product = a * b;

    // everything is computed one bit wider, the extra bit is the carry out
    // pass, logic and multiply keep it at zero by construction
    always_comb begin
        wide  = '0;
        valid = 1'b1;
        case (op_eff)
            alu_ops_pkg::OP_A:      wide = ext_a;
            alu_ops_pkg::OP_B:      wide = ext_b;
            alu_ops_pkg::OP_ZERO:   wide = '0;
            alu_ops_pkg::OP_NEG_A:  wide = -ext_a;
            alu_ops_pkg::OP_NEG_B:  wide = -ext_b;
            alu_ops_pkg::OP_INC_A:  wide = ext_a + ONE;
            alu_ops_pkg::OP_INC_B:  wide = ext_b + ONE;
            alu_ops_pkg::OP_DEC_A:  wide = ext_a - ONE;
            alu_ops_pkg::OP_DEC_B:  wide = ext_b - ONE;
            // for subtraction the top bit reads as a borrow
            alu_ops_pkg::OP_ADD:    wide = ext_a + ext_b + ext_cin;
            alu_ops_pkg::OP_SUB:    wide = ext_a - ext_b - ext_cin;
            alu_ops_pkg::OP_MUL_HI: wide = {1'b0, product[2*`ALU_DATA_W-1:`ALU_DATA_W]};
            alu_ops_pkg::OP_MUL_LO: wide = {1'b0, product[`ALU_DATA_W-1:0]};
            alu_ops_pkg::OP_AND:    wide = {1'b0, a & b};
            alu_ops_pkg::OP_OR:     wide = {1'b0, a | b};
            default: begin
                // unlisted code, the controller will not commit anything
                wide  = '0;
                valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        res.result      = wide[`ALU_DATA_W-1:0];
        res.flags.carry = wide[`ALU_DATA_W];
        res.flags.zero  = (wide[`ALU_DATA_W-1:0] == '0);
        res.op_valid    = valid;
    end

    // an invalid op must never leak a stale or partial result
    always_comb begin
        a_invalid_zero: assert (res.op_valid || res.result == '0)
            else $error("alu result %0h for invalid op %0d", res.result, req.op);
    end

endmodule

// File: src/reg_file.sv
`include "alu_config.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      we,
    input  logic [`ALU_REG_SEL_W-1:0] waddr,
    input  logic [`ALU_DATA_W-1:0]    wdata,
    input  logic [`ALU_REG_SEL_W-1:0] raddr_x,
    input  logic [`ALU_REG_SEL_W-1:0] raddr_y,
    input  logic [`ALU_REG_SEL_W-1:0] raddr_bus,
    output logic [`ALU_DATA_W-1:0]    rdata_x,
    output logic [`ALU_DATA_W-1:0]    rdata_y,
    output logic [`ALU_DATA_W-1:0]    rdata_bus
);

    logic [`ALU_DATA_W-1:0] regs [`ALU_NUM_REGS];

    // operand registers start from zero so reads after reset are defined
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ALU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // two operand ports feed the ALU, the third serves bus reads
    assign rdata_x   = regs[raddr_x];
    assign rdata_y   = regs[raddr_y];
    assign rdata_bus = regs[raddr_bus];

    a_we_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(we))
        else $error("register file write enable is unknown");

endmodule

// File: src/alu_ctrl.sv
`include "alu_config.svh"

module alu_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  axil_pkg::axil_aw_t        aw,
    input  logic                      w_valid,
    output logic                      w_ready,
    input  axil_pkg::axil_w_t         w,
    output logic                      b_valid,
    input  logic                      b_ready,
    output axil_pkg::axil_b_t         b,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    input  axil_pkg::axil_ar_t        ar,
    output logic                      r_valid,
    input  logic                      r_ready,
    output axil_pkg::axil_r_t         r,
    output alu_ops_pkg::alu_req_t     alu_req,
    input  alu_ops_pkg::alu_res_t     alu_res,
    output logic                      we,
    output logic [`ALU_REG_SEL_W-1:0] waddr,
    output logic [`ALU_DATA_W-1:0]    wdata,
    output logic [`ALU_REG_SEL_W-1:0] raddr_x,
    output logic [`ALU_REG_SEL_W-1:0] raddr_y,
    output logic [`ALU_REG_SEL_W-1:0] raddr_bus,
    input  logic [`ALU_DATA_W-1:0]    rdata_x,
    input  logic [`ALU_DATA_W-1:0]    rdata_y,
    input  logic [`ALU_DATA_W-1:0]    rdata_bus
);

    typedef struct packed {
        logic                      reg_hit;
        logic                      cmd_hit;
        logic                      flags_hit;
        logic [`ALU_REG_SEL_W-1:0] idx;
    } decode_t;

    // shared by the read and write channels, unaligned offsets count as unmapped
    function automatic decode_t decode(input logic [`AXIL_ADDR_W-1:0] addr);
        logic [`AXIL_ADDR_W-1:0] offs;
        decode_t                 d;
        offs        = addr - `AXIL_ADDR_W'(`ALU_REG_BASE);
        d.reg_hit   = (offs < `AXIL_ADDR_W'(4 * `ALU_NUM_REGS)) && (offs[1:0] == 2'b00);
        d.cmd_hit   = (addr == `AXIL_ADDR_W'(`ALU_CMD_ADDR));
        d.flags_hit = (addr == `AXIL_ADDR_W'(`ALU_FLAGS_ADDR));
        d.idx       = offs[`ALU_REG_SEL_W+1:2];
        return d;
    endfunction

    logic                    live;
    logic                    wr_fire;
    logic                    rd_fire;
    logic                    commit;
    decode_t                 wr_dec;
    decode_t                 rd_dec;
    alu_ops_pkg::alu_cmd_t   cmd;
    alu_ops_pkg::alu_flags_t flags;
    axil_pkg::axil_resp_e    wr_resp;

    assign wr_dec = decode(aw.addr);
    assign rd_dec = decode(ar.addr);
    assign cmd    = alu_ops_pkg::alu_cmd_t'(w.data[15:0]);

    // address and data are taken together, and only with the B slot free
    assign aw_ready = live && aw_valid && w_valid && !b_valid;
    assign w_ready  = aw_ready;
    assign ar_ready = live && !r_valid;
    assign wr_fire  = aw_ready;
    assign rd_fire  = ar_valid && ar_ready;

    // the request is formed straight from the incoming command word
    assign raddr_x = cmd.sel_x;
    assign raddr_y = cmd.sel_y;

    always_comb begin
        alu_req.x            = rdata_x;
        alu_req.y            = rdata_y;
        alu_req.op           = cmd.op;
        alu_req.force_pass_x = cmd.force_pass_x;
        alu_req.force_x_zero = cmd.force_x_zero;
        alu_req.cin          = flags.carry;
    end

    assign commit    = wr_dec.cmd_hit && alu_res.op_valid;
    assign we        = wr_fire && (wr_dec.reg_hit || commit);
    assign waddr     = wr_dec.reg_hit ? wr_dec.idx : cmd.sel_dst;
    assign wdata     = wr_dec.reg_hit ? w.data[`ALU_DATA_W-1:0] : alu_res.result;
    assign raddr_bus = rd_dec.idx;
    assign wr_resp   = (wr_dec.reg_hit || commit) ? axil_pkg::OKAY : axil_pkg::SLVERR;

    // live holds the ready outputs low until the first edge out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live    <= 1'b0;
            b_valid <= 1'b0;
            r_valid <= 1'b0;
            flags   <= '0;
        end else begin
            live <= 1'b1;
            if (wr_fire) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
            if (rd_fire) begin
                r_valid <= 1'b1;
            end else if (r_ready) begin
                r_valid <= 1'b0;
            end
            if (wr_fire && commit) begin
                flags <= alu_res.flags;
            end
        end
    end

    // read data is sampled before any same-cycle write lands
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            b.resp <= wr_resp;
        end
        if (rd_fire) begin
            if (rd_dec.reg_hit) begin
                r.data <= `AXIL_DATA_W'(rdata_bus);
                r.resp <= axil_pkg::OKAY;
            end else if (rd_dec.flags_hit) begin
                r.data <= `AXIL_DATA_W'(flags);
                r.resp <= axil_pkg::OKAY;
            end else begin
                r.data <= '0;
                r.resp <= axil_pkg::SLVERR;
            end
        end
    end

    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else $error("write response dropped or changed before b_ready");

    a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else $error("read response dropped or changed before r_ready");

endmodule

// File: src/alu_datapath_top.sv
`include "alu_config.svh"

module alu_datapath_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  axil_pkg::axil_aw_t aw,
    input  logic               w_valid,
    output logic               w_ready,
    input  axil_pkg::axil_w_t  w,
    output logic               b_valid,
    input  logic               b_ready,
    output axil_pkg::axil_b_t  b,
    input  logic               ar_valid,
    output logic               ar_ready,
    input  axil_pkg::axil_ar_t ar,
    output logic               r_valid,
    input  logic               r_ready,
    output axil_pkg::axil_r_t  r
);

    alu_ops_pkg::alu_req_t     alu_req;
    alu_ops_pkg::alu_res_t     alu_res;
    logic                      we;
    logic [`ALU_REG_SEL_W-1:0] waddr;
    logic [`ALU_DATA_W-1:0]    wdata;
    logic [`ALU_REG_SEL_W-1:0] raddr_x;
    logic [`ALU_REG_SEL_W-1:0] raddr_y;
    logic [`ALU_REG_SEL_W-1:0] raddr_bus;
    logic [`ALU_DATA_W-1:0]    rdata_x;
    logic [`ALU_DATA_W-1:0]    rdata_y;
    logic [`ALU_DATA_W-1:0]    rdata_bus;

    // bus slave, decode and flags
    alu_ctrl i_alu_ctrl (.*);

    // port names match the local wires one to one
    reg_file i_reg_file (.*);

    alu i_alu (
        .req (alu_req),
        .res (alu_res)
    );

endmodule

// File: sim/alu_ref_model.svh
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// shadow copy of the operand registers and the flags register
logic [`ALU_DATA_W-1:0]  model_regs [`ALU_NUM_REGS];
alu_ops_pkg::alu_flags_t model_flags;

function automatic void model_reset();
    for (int i = 0; i < `ALU_NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    model_flags = '0;
endfunction

// evaluates a command word against the shadow state, returns 0 for a code outside the table
function automatic logic model_alu(input logic [`AXIL_DATA_W-1:0] word,
                                   output logic [`ALU_DATA_W-1:0] result,
                                   output alu_ops_pkg::alu_flags_t flags);
    int   a;
    int   b;
    int   cin;
    int   op;
    int   full;
    logic valid;
    a     = word[6] ? 0 : int'(model_regs[word[9:8]]);
    b     = int'(model_regs[word[11:10]]);
    cin   = int'(model_flags.carry);
    op    = word[5] ? 0 : int'(word[4:0]);
    valid = 1'b1;
    case (op)
        0:  full = a;
        1:  full = b;
        2:  full = 0;
        3:  full = -a;
        4:  full = -b;
        5:  full = a + 1;
        6:  full = b + 1;
        7:  full = a - 1;
        8:  full = b - 1;
        9:  full = a + b + cin;
        10: full = a - b - cin;
        16: full = (a * b) >> 8;
        17: full = (a * b) & 'hff;
        25: full = a & b;
        26: full = a | b;
        default: begin
            full  = 0;
            valid = 1'b0;
        end
    endcase
    // nine bits kept, the top one is the carry or borrow
    full        = full & 'h1ff;
    result      = full[7:0];
    flags.carry = full[8];
    flags.zero  = (full[7:0] == 0);
    return valid;
endfunction

function automatic axil_pkg::axil_resp_e model_write(input logic [`AXIL_ADDR_W-1:0] addr,
                                                     input logic [`AXIL_DATA_W-1:0] data);
    logic [`ALU_DATA_W-1:0]  result;
    alu_ops_pkg::alu_flags_t flags;
    logic                    valid;
    if (addr < 4 * `ALU_NUM_REGS && addr[1:0] == 2'b00) begin
        model_regs[addr[`ALU_REG_SEL_W+1:2]] = data[`ALU_DATA_W-1:0];
        return axil_pkg::OKAY;
    end
    if (addr == `ALU_CMD_ADDR) begin
        valid = model_alu(data, result, flags);
        if (valid) begin
            model_regs[data[13:12]] = result;
            model_flags             = flags;
            return axil_pkg::OKAY;
        end
    end
    return axil_pkg::SLVERR;
endfunction

function automatic axil_pkg::axil_resp_e model_read(input logic [`AXIL_ADDR_W-1:0] addr,
                                                    output logic [`AXIL_DATA_W-1:0] data);
    data = '0;
    if (addr < 4 * `ALU_NUM_REGS && addr[1:0] == 2'b00) begin
        data = `AXIL_DATA_W'(model_regs[addr[`ALU_REG_SEL_W+1:2]]);
        return axil_pkg::OKAY;
    end
    if (addr == `ALU_FLAGS_ADDR) begin
        data = `AXIL_DATA_W'(model_flags);
        return axil_pkg::OKAY;
    end
    return axil_pkg::SLVERR;
endfunction

`endif

// File: sim/tb_alu_datapath.sv
`include "alu_config.svh"

module tb_alu_datapath;

    localparam int TIMEOUT = 20;

    logic               clk;
    logic               arst_n;
    logic               aw_valid;
    logic               aw_ready;
    logic               w_valid;
    logic               w_ready;
    logic               b_valid;
    logic               b_ready;
    logic               ar_valid;
    logic               ar_ready;
    logic               r_valid;
    logic               r_ready;
    axil_pkg::axil_aw_t aw;
    axil_pkg::axil_w_t  w;
    axil_pkg::axil_b_t  b;
    axil_pkg::axil_ar_t ar;
    axil_pkg::axil_r_t  r;

    int valid_ops [15] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 16, 17, 25, 26};
    int invalid_ops [17] = '{11, 12, 13, 14, 15, 18, 19, 20, 21, 22, 23, 24, 27, 28, 29, 30, 31};

    alu_datapath_top i_alu_datapath_top (.*);

    `include "alu_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input logic [`ALU_DATA_W-1:0] exp,
                              input logic [`ALU_DATA_W-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL time %0t %s expected %02h got %02h", $time, name, exp, act));
        end
    endtask

    task automatic check_flags(input string name, input alu_ops_pkg::alu_flags_t exp,
                               input alu_ops_pkg::alu_flags_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL time %0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    task automatic check_resp(input string name, input axil_pkg::axil_resp_e exp,
                              input axil_pkg::axil_resp_e act);
        if (act !== exp) begin
            abort_run($sformatf("FAIL time %0t %s expected %b got %b", $time, name, exp, act));
        end
    endtask

    // inputs change one time unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_write(input logic [`AXIL_ADDR_W-1:0] addr,
                              input logic [`AXIL_DATA_W-1:0] data);
        logic done;
        aw_valid = 1'b1;
        aw.addr  = addr;
        w_valid  = 1'b1;
        w.data   = data;
        w.strb   = '1;
        done     = 1'b0;
        for (int n = 0; !done; n++) begin
            if (n == TIMEOUT) begin
                abort_run("timeout waiting for the write address and data to be accepted");
            end
            @(negedge clk);
            if (aw_ready !== w_ready) begin
                abort_run("write address and write data were not accepted together");
            end
            done = aw_ready && w_ready;
            next_cycle();
        end
        aw_valid = 1'b0;
        w_valid  = 1'b0;
    endtask

    // bready stays low for the given number of cycles after the response shows up
    task automatic collect_write_resp(input int stall, output axil_pkg::axil_resp_e resp);
        logic done;
        done    = 1'b0;
        b_ready = (stall == 0);
        for (int n = 0; !done; n++) begin
            if (n == TIMEOUT) begin
                abort_run("timeout waiting for the write response handshake");
            end
            @(negedge clk);
            if (n == 0 && !b_valid) begin
                abort_run("write response did not arrive one cycle after acceptance");
            end
            done = b_valid && b_ready;
            resp = b.resp;
            next_cycle();
            b_ready = (n + 1 >= stall);
        end
        b_ready = 1'b0;
    endtask

    task automatic axil_write(input logic [`AXIL_ADDR_W-1:0] addr,
                              input logic [`AXIL_DATA_W-1:0] data,
                              output axil_pkg::axil_resp_e resp);
        send_write(addr, data);
        collect_write_resp($urandom_range(0, 3), resp);
    endtask

    task automatic axil_read(input logic [`AXIL_ADDR_W-1:0] addr,
                             output logic [`AXIL_DATA_W-1:0] data,
                             output axil_pkg::axil_resp_e resp);
        int   stall;
        logic done;
        stall    = $urandom_range(0, 3);
        ar_valid = 1'b1;
        ar.addr  = addr;
        done     = 1'b0;
        for (int n = 0; !done; n++) begin
            if (n == TIMEOUT) begin
                abort_run("timeout waiting for the read address to be accepted");
            end
            @(negedge clk);
            done = ar_ready;
            next_cycle();
        end
        ar_valid = 1'b0;
        r_ready  = (stall == 0);
        done     = 1'b0;
        for (int n = 0; !done; n++) begin
            if (n == TIMEOUT) begin
                abort_run("timeout waiting for the read data handshake");
            end
            @(negedge clk);
            if (n == 0 && !r_valid) begin
                abort_run("read data did not arrive one cycle after acceptance");
            end
            done = r_valid && r_ready;
            data = r.data;
            resp = r.resp;
            next_cycle();
            r_ready = (n + 1 >= stall);
        end
        r_ready = 1'b0;
    endtask

    task automatic write_compare(input logic [`AXIL_ADDR_W-1:0] addr,
                                 input logic [`AXIL_DATA_W-1:0] data);
        axil_pkg::axil_resp_e resp;
        axil_write(addr, data, resp);
        check_resp("bresp", model_write(addr, data), resp);
    endtask

    task automatic read_compare(input logic [`AXIL_ADDR_W-1:0] addr);
        logic [`AXIL_DATA_W-1:0] data;
        logic [`AXIL_DATA_W-1:0] exp_data;
        logic [`AXIL_DATA_W-1:0] field_mask;
        axil_pkg::axil_resp_e    resp;
        axil_read(addr, data, resp);
        check_resp("rresp", model_read(addr, exp_data), resp);
        if (addr == `ALU_FLAGS_ADDR) begin
            field_mask = `AXIL_DATA_W'(2'b11);
            check_flags("flags", alu_ops_pkg::alu_flags_t'(exp_data[1:0]),
                        alu_ops_pkg::alu_flags_t'(data[1:0]));
        end else begin
            field_mask = `AXIL_DATA_W'({`ALU_DATA_W{1'b1}});
            check_data("rdata", exp_data[`ALU_DATA_W-1:0], data[`ALU_DATA_W-1:0]);
        end
        // everything above the register field is zero extension
        if ((data & ~field_mask) !== (exp_data & ~field_mask)) begin
            abort_run($sformatf("FAIL time %0t rdata upper bits expected %08h got %08h",
                                $time, exp_data & ~field_mask, data & ~field_mask));
        end
    endtask

    // builds a command word with random register selects around the given op and force bits
    function automatic logic [`AXIL_DATA_W-1:0] make_command(input int op, input logic pass_x,
                                                             input logic zero_x);
        logic [`AXIL_DATA_W-1:0] word;
        word       = '0;
        word[4:0]  = op[4:0];
        word[5]    = pass_x;
        word[6]    = zero_x;
        word[13:8] = 6'($urandom);
        return word;
    endfunction

    task automatic run_command(input int op, input logic pass_x, input logic zero_x);
        logic [`AXIL_DATA_W-1:0] word;
        word = make_command(op, pass_x, zero_x);
        write_compare(`AXIL_ADDR_W'(`ALU_CMD_ADDR), word);
        read_compare(`AXIL_ADDR_W'(4 * word[13:12]));
        read_compare(`AXIL_ADDR_W'(`ALU_FLAGS_ADDR));
    endtask

    // a second write waits while the first response is held and goes through once it completes
    task automatic write_blocking_test();
        logic [`AXIL_DATA_W-1:0] first;
        logic [`AXIL_DATA_W-1:0] second;
        axil_pkg::axil_resp_e    resp;
        first  = $urandom;
        second = $urandom;
        send_write(`AXIL_ADDR_W'(0), first);
        aw_valid = 1'b1;
        aw.addr  = `AXIL_ADDR_W'(4);
        w_valid  = 1'b1;
        w.data   = second;
        repeat (3) begin
            @(negedge clk);
            if (!b_valid || aw_ready || w_ready) begin
                abort_run("a second write was accepted while the write response was held");
            end
            next_cycle();
        end
        collect_write_resp(0, resp);
        check_resp("bresp", model_write(`AXIL_ADDR_W'(0), first), resp);
        send_write(`AXIL_ADDR_W'(4), second);
        collect_write_resp(0, resp);
        check_resp("bresp", model_write(`AXIL_ADDR_W'(4), second), resp);
        read_compare(`AXIL_ADDR_W'(0));
        read_compare(`AXIL_ADDR_W'(4));
    endtask

    initial begin
        void'($urandom(50578));
        arst_n   = 1'b0;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        model_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (aw_ready || w_ready || ar_ready || b_valid || r_valid) begin
            abort_run("bus handshake outputs are active during reset");
        end
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        next_cycle();

        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            read_compare(`AXIL_ADDR_W'(4 * i));
        end
        read_compare(`AXIL_ADDR_W'(`ALU_FLAGS_ADDR));

        repeat (40) begin
            write_compare(`AXIL_ADDR_W'(4 * $urandom_range(0, 3)), $urandom);
        end
        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            read_compare(`AXIL_ADDR_W'(4 * i));
        end

        // operands are refreshed now and then so results do not collapse to zero
        repeat (300) begin
            if ($urandom_range(0, 3) == 0) begin
                write_compare(`AXIL_ADDR_W'(4 * $urandom_range(0, 3)), $urandom);
            end
            run_command(valid_ops[$urandom_range(0, 14)], 1'b0, 1'b0);
        end

        repeat (40) begin
            run_command(valid_ops[$urandom_range(0, 14)], 1'b0, 1'b1);
        end
        repeat (40) begin
            run_command($urandom_range(0, 31), 1'b1, 1'($urandom));
        end

        repeat (30) begin
            run_command(invalid_ops[$urandom_range(0, 16)], 1'b0, 1'($urandom));
        end
        write_compare(`AXIL_ADDR_W'(`ALU_FLAGS_ADDR), $urandom);
        write_compare(`AXIL_ADDR_W'('h18), $urandom);
        write_compare(`AXIL_ADDR_W'('h02), $urandom);
        write_compare(`AXIL_ADDR_W'('hfc), $urandom);
        read_compare(`AXIL_ADDR_W'(`ALU_CMD_ADDR));
        read_compare(`AXIL_ADDR_W'('h18));
        read_compare(`AXIL_ADDR_W'('h03));
        for (int i = 0; i < `ALU_NUM_REGS; i++) begin
            read_compare(`AXIL_ADDR_W'(4 * i));
        end
        read_compare(`AXIL_ADDR_W'(`ALU_FLAGS_ADDR));

        write_blocking_test();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: alu_datapath.f
+incdir+src
+incdir+sim
src/alu_ops_pkg.sv
src/axil_pkg.sv
src/alu.sv
src/reg_file.sv
src/alu_ctrl.sv
src/alu_datapath_top.sv
sim/tb_alu_datapath.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_alu_datapath -f alu_datapath.f

./obj_dir/Vtb_alu_datapath | tee sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    echo "run_sim: simulation run passed"
else
    echo "run_sim: simulation run failed"
    exit 1
fi
